/* Bender.yml */
package:
  name: spyhunt_glue

sources:
  - include_dirs:
      - design
    files:
      - design/spyhunt_pkg.sv
      - design/dl_if.sv
      - design/rom_loader.sv
      - design/reset_seq.sv
      - design/drive_controls.sv
      - design/audio_dac.sv
      - design/spyhunt_glue.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/spyhunt_sva.sv
      - test/spyhunt_checker.sv
      - test/tb_spyhunt.sv

/* design/audio_dac.sv */
// audio pin driver
//   mixes the deluxe sound board into one channel
//   first order sigma-delta modulator, one bit output

`default_nettype none

module audio_dac #(
	parameter int width = 16
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [width-1:0] main_audio,
	input  logic [9:0]       csd_audio,
	output logic             dac_out
);

	logic [width-1:0] mix;
	logic [width-1:0] acc;
	logic [width:0]   sum;

	// csd board sits 5 bits up, sum wraps at the channel width
	assign mix = main_audio + width'({csd_audio, 5'd0});

	assign sum = {1'b0, acc} + {1'b0, mix};

	// carry out is the pulse density, remainder stays in the accumulator
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[width-1:0];
			dac_out <= sum[width];
		end
	end

endmodule

`default_nettype wire

/* design/dl_if.sv */
// ROM download stream
//   source modport for the driver, sink modport for the consumers

`default_nettype none

interface dl_if;

	logic        downloading;
	logic        wr;
	logic [24:0] addr;
	logic [7:0]  data;

	modport source (
		output downloading,
		output wr,
		output addr,
		output data
	);

	modport sink (
		input downloading,
		input wr,
		input addr,
		input data
	);

endinterface

`default_nettype wire

/* design/drive_controls.sv */
// driving controls emulation
//   steering wheel and gas pedal ramped from digital buttons,
//   gear lever toggled by the shift button

`default_nettype none

`include "spyhunt_settings.svh"

module drive_controls (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       vsync,
	input  logic       gas_up,
	input  logic       gas_down,
	input  logic       steer_right,
	input  logic       steer_left,
	input  logic       shift,
	input  logic       coin,
	output logic [7:0] steering,
	output logic [7:0] gas,
	output logic       gear
);

	logic vsync_q;
	logic vsync_qq;
	logic vsync_rise;
	logic shift_q;
	logic shift_qq;
	logic shift_rise;
	logic gas_up_q;
	logic gas_down_q;
	logic right_q;
	logic left_q;
	logic coin_q;

	function automatic logic [7:0] step_up(input logic [7:0] v);
		logic [8:0] sum;
		sum = {1'b0, v} + {1'b0, `SPY_RAMP_STEP};
		return sum[8] ? 8'hff : sum[7:0];
	endfunction

	function automatic logic [7:0] step_down(input logic [7:0] v);
		return (v < `SPY_RAMP_STEP) ? 8'h00 : v - `SPY_RAMP_STEP;
	endfunction

	// wheel springs back, stops exactly on center
	function automatic logic [7:0] to_center(input logic [7:0] v);
		if (v > `SPY_STEER_CENTER)
			return (v - `SPY_STEER_CENTER > `SPY_RAMP_STEP) ? v - `SPY_RAMP_STEP :
				`SPY_STEER_CENTER;
		else if (v < `SPY_STEER_CENTER)
			return (`SPY_STEER_CENTER - v > `SPY_RAMP_STEP) ? v + `SPY_RAMP_STEP :
				`SPY_STEER_CENTER;
		else
			return v;
	endfunction

	// ======================================================================
	// input capture and edge detect
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vsync_q    <= 1'b0;
			vsync_qq   <= 1'b0;
			vsync_rise <= 1'b0;
			shift_q    <= 1'b0;
			shift_qq   <= 1'b0;
			shift_rise <= 1'b0;
			gas_up_q   <= 1'b0;
			gas_down_q <= 1'b0;
			right_q    <= 1'b0;
			left_q     <= 1'b0;
			coin_q     <= 1'b0;
		end else begin
			vsync_q    <= vsync;
			vsync_qq   <= vsync_q;
			vsync_rise <= vsync_q & ~vsync_qq;
			shift_q    <= shift;
			shift_qq   <= shift_q;
			shift_rise <= shift_q & ~shift_qq;
			gas_up_q   <= gas_up;
			gas_down_q <= gas_down;
			right_q    <= steer_right;
			left_q     <= steer_left;
			coin_q     <= coin;
		end
	end

	// ======================================================================
	// once per frame ramp
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			steering <= `SPY_STEER_CENTER;
			gas      <= 8'h00;
			gear     <= 1'b0;
		end else begin
			if (vsync_rise) begin
				// plus direction wins when both are held
				if (right_q)
					steering <= step_up(steering);
				else if (left_q)
					steering <= step_down(steering);
				else
					steering <= to_center(steering);

				if (gas_up_q)
					gas <= step_up(gas);
				else if (gas_down_q)
					gas <= step_down(gas);
			end
			// a new coin puts the car back in low gear
			if (coin_q)
				gear <= 1'b0;
			else if (shift_rise)
				gear <= ~gear;
		end
	end

endmodule

`default_nettype wire

/* design/reset_seq.sv */
// game reset sequencer
//   loaded flag, reset hold and the delayed second reset pulse

`default_nettype none

`include "spyhunt_settings.svh"

module reset_seq (
	input  logic clk_sys,
	input  logic rst_n,
	dl_if.sink   dl,
	input  logic reset_req,
	output logic game_reset,
	output logic rom_loaded
);

	logic        dl_q;
	logic        hold;
	logic [15:0] hold_cnt;

	assign hold = reset_req | ~rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_q       <= 1'b0;
			rom_loaded <= 1'b0;
			hold_cnt   <= `SPY_RESET_HOLD;
			game_reset <= 1'b1;
		end else begin
			dl_q <= dl.downloading;
			// end of a download, later downloads keep the flag
			if (dl_q && !dl.downloading)
				rom_loaded <= 1'b1;
			// count starts once the first reset has dropped
			if (hold)
				hold_cnt <= `SPY_RESET_HOLD;
			else if (hold_cnt != 16'd0 && !game_reset)
				hold_cnt <= hold_cnt - 16'd1;
			// the cpus need a second short reset after startup
			game_reset <= hold || (hold_cnt == 16'd1);
		end
	end

endmodule

`default_nettype wire

/* design/rom_loader.sv */
// ROM download sorter
//   region decode of each byte, per port address scramble,
//   toggle request handshake on two memory ports, overrun flag

`default_nettype none

`include "spyhunt_settings.svh"

module rom_loader (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	dl_if.sink                      dl,
	output logic                    mem1_req,
	input  logic                    mem1_ack,
	output spyhunt_pkg::mem_write_t mem1_wr,
	output logic                    mem2_req,
	input  logic                    mem2_ack,
	output spyhunt_pkg::mem_write_t mem2_wr,
	output logic                    load_err
);

	logic                    wr_q;
	logic                    wr_qq;
	logic                    dl_q;
	logic [24:0]             addr_q;
	logic [7:0]              data_q;
	logic                    strobe;
	spyhunt_pkg::rom_region_e region;
	logic [24:0]             port1_src;
	logic [24:0]             spr_off;
	spyhunt_pkg::mem_write_t port1_next;
	spyhunt_pkg::mem_write_t port2_next;
	logic                    take1;
	logic                    take2;
	logic                    busy1;
	logic                    busy2;

	// ======================================================================
	// capture stage
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_q  <= 1'b0;
			wr_qq <= 1'b0;
			dl_q  <= 1'b0;
		end else begin
			wr_q  <= dl.wr;
			wr_qq <= wr_q;
			dl_q  <= dl.downloading;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= dl.addr;
		data_q <= dl.data;
	end

	assign strobe = wr_q & ~wr_qq & dl_q;

	always_comb begin
		if (addr_q < `SPY_SOUND_BASE)
			region = spyhunt_pkg::main_cpu;
		else if (addr_q < `SPY_CSD_BASE)
			region = spyhunt_pkg::sound_cpu;
		else if (addr_q < `SPY_SPRITE_BASE)
			region = spyhunt_pkg::csd;
		else if (addr_q < `SPY_IGNORE_BASE)
			region = spyhunt_pkg::sprite;
		else
			region = spyhunt_pkg::ignored;
	end

	// ======================================================================
	// address scramble
	// ======================================================================
	// csd ROM is 16 bit wide, bit 14 picks the byte within the word
	assign port1_src = (region == spyhunt_pkg::csd) ?
		{addr_q[24:15], addr_q[13:0], addr_q[14]} : addr_q;

	assign port1_next.addr = port1_src[23:1];
	assign port1_next.ds   = {port1_src[0], ~port1_src[0]};
	assign port1_next.data = {data_q, data_q};

	// sprite ROMs merge into 32 bit words over two memory words
	assign spr_off = addr_q - `SPY_SPRITE_BASE;

	assign port2_next.addr = {spr_off[23:17], spr_off[14:0], spr_off[16]};
	assign port2_next.ds   = {spr_off[15], ~spr_off[15]};
	assign port2_next.data = {data_q, data_q};

	// ======================================================================
	// request handshake
	// ======================================================================
	assign take1 = strobe && (region inside {spyhunt_pkg::main_cpu,
		spyhunt_pkg::sound_cpu, spyhunt_pkg::csd});
	assign take2 = strobe && (region == spyhunt_pkg::sprite);
	assign busy1 = mem1_req != mem1_ack;
	assign busy2 = mem2_req != mem2_ack;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mem1_req <= 1'b0;
			mem2_req <= 1'b0;
			load_err <= 1'b0;
		end else begin
			if (take1 && !busy1)
				mem1_req <= ~mem1_req;
			if (take2 && !busy2)
				mem2_req <= ~mem2_req;
			// byte lost, memory still busy with the previous one
			if ((take1 && busy1) || (take2 && busy2))
				load_err <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take1 && !busy1)
			mem1_wr <= port1_next;
		if (take2 && !busy2)
			mem2_wr <= port2_next;
	end

endmodule

`default_nettype wire

/* design/spyhunt_glue.sv */
// board glue top level
//   ROM download sorting, game reset sequencing,
//   driving controls and the two audio converters

`default_nettype none

`include "spyhunt_settings.svh"

module spyhunt_glue (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        dl_downloading,
	input  logic                        dl_wr,
	input  logic [24:0]                 dl_addr,
	input  logic [7:0]                  dl_data,
	output logic                        mem1_req,
	input  logic                        mem1_ack,
	output logic [22:0]                 mem1_addr,
	output logic [1:0]                  mem1_ds,
	output logic [15:0]                 mem1_data,
	output logic                        mem2_req,
	input  logic                        mem2_ack,
	output logic [22:0]                 mem2_addr,
	output logic [1:0]                  mem2_ds,
	output logic [15:0]                 mem2_data,
	output logic                        load_err,
	input  logic                        reset_req,
	output logic                        game_reset,
	output logic                        rom_loaded,
	input  logic                        vsync,
	input  logic                        gas_up,
	input  logic                        gas_down,
	input  logic                        steer_right,
	input  logic                        steer_left,
	input  logic                        shift,
	input  logic                        coin,
	output logic [7:0]                  steering,
	output logic [7:0]                  gas,
	output logic                        gear,
	input  logic [`SPY_AUDIO_WIDTH-1:0] audio_l_in,
	input  logic [`SPY_AUDIO_WIDTH-1:0] audio_r_in,
	input  logic [9:0]                  csd_audio,
	output logic                        audio_l,
	output logic                        audio_r
);

	spyhunt_pkg::mem_write_t mem1_wr;
	spyhunt_pkg::mem_write_t mem2_wr;

	dl_if dl ();

	assign dl.downloading = dl_downloading;
	assign dl.wr          = dl_wr;
	assign dl.addr        = dl_addr;
	assign dl.data        = dl_data;

	rom_loader u_rom_loader (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dl       (dl.sink),
		.mem1_req (mem1_req),
		.mem1_ack (mem1_ack),
		.mem1_wr  (mem1_wr),
		.mem2_req (mem2_req),
		.mem2_ack (mem2_ack),
		.mem2_wr  (mem2_wr),
		.load_err (load_err)
	);

	assign mem1_addr = mem1_wr.addr;
	assign mem1_ds   = mem1_wr.ds;
	assign mem1_data = mem1_wr.data;
	assign mem2_addr = mem2_wr.addr;
	assign mem2_ds   = mem2_wr.ds;
	assign mem2_data = mem2_wr.data;

	reset_seq u_reset_seq (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl.sink),
		.reset_req  (reset_req),
		.game_reset (game_reset),
		.rom_loaded (rom_loaded)
	);

	drive_controls u_drive_controls (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.vsync       (vsync),
		.gas_up      (gas_up),
		.gas_down    (gas_down),
		.steer_right (steer_right),
		.steer_left  (steer_left),
		.shift       (shift),
		.coin        (coin),
		.steering    (steering),
		.gas         (gas),
		.gear        (gear)
	);

	// both channels carry the same csd board signal
	audio_dac #(.width(`SPY_AUDIO_WIDTH)) u_dac_l (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.main_audio (audio_l_in),
		.csd_audio  (csd_audio),
		.dac_out    (audio_l)
	);

	audio_dac #(.width(`SPY_AUDIO_WIDTH)) u_dac_r (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.main_audio (audio_r_in),
		.csd_audio  (csd_audio),
		.dac_out    (audio_r)
	);

endmodule

`default_nettype wire

/* design/spyhunt_pkg.sv */
// shared types of the cabinet glue
//   rom_region_e  region of one downloaded ROM byte
//   mem_write_t   one write towards an external memory port

`default_nettype none

package spyhunt_pkg;

	// ======================================================================
	// download regions
	// ======================================================================
	// background and character regions are folded into ignored
	typedef enum logic [2:0] {
		main_cpu,
		sound_cpu,
		csd,
		sprite,
		ignored
	} rom_region_e;

	// ======================================================================
	// memory write
	// ======================================================================
	// the byte sits on both lanes, ds picks the one that is written
	typedef struct packed {
		logic [22:0] addr;
		logic [1:0]  ds;
		logic [15:0] data;
	} mem_write_t;

endpackage

`default_nettype wire

/* design/spyhunt_settings.svh */
// build constants of the cabinet glue
//   download address map, reset hold time, control ramp, audio width

`ifndef SPYHUNT_SETTINGS_SVH
`define SPYHUNT_SETTINGS_SVH

// ======================================================================
// download address map, byte addresses
// ======================================================================
`define SPY_SOUND_BASE   25'h000E000
`define SPY_CSD_BASE     25'h0010000
`define SPY_SPRITE_BASE  25'h0018000
`define SPY_IGNORE_BASE  25'h0038000

// gap before the second reset pulse, 65535 on the board
`define SPY_RESET_HOLD   16'd16

// analog control emulation
`define SPY_RAMP_STEP    8'd4
`define SPY_STEER_CENTER 8'h80

`define SPY_AUDIO_WIDTH  16

`endif

/* tb.f */
+incdir+design
design/spyhunt_pkg.sv
design/dl_if.sv
design/rom_loader.sv
design/reset_seq.sv
design/drive_controls.sv
design/audio_dac.sv
design/spyhunt_glue.sv
test/spyhunt_sva.sv
test/spyhunt_checker.sv
test/tb_spyhunt.sv

/* test/spyhunt_checker.sv */
// checker of the board glue
//   reference remap, ramp and sigma-delta functions
//   cycle models of reset sequence and control latency, error count

`default_nettype none

`include "spyhunt_settings.svh"

module spyhunt_checker (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        dl_downloading,
	input  logic        dl_wr,
	input  logic [24:0] dl_addr,
	input  logic [7:0]  dl_data,
	input  logic        mem1_req,
	input  logic        mem1_ack,
	input  logic [22:0] mem1_addr,
	input  logic [1:0]  mem1_ds,
	input  logic [15:0] mem1_data,
	input  logic        mem2_req,
	input  logic        mem2_ack,
	input  logic [22:0] mem2_addr,
	input  logic [1:0]  mem2_ds,
	input  logic [15:0] mem2_data,
	input  logic        load_err,
	input  logic        reset_req,
	input  logic        game_reset,
	input  logic        rom_loaded,
	input  logic        vsync,
	input  logic        gas_up,
	input  logic        gas_down,
	input  logic        steer_right,
	input  logic        steer_left,
	input  logic        shift,
	input  logic        coin,
	input  logic [7:0]  steering,
	input  logic [7:0]  gas,
	input  logic        gear,
	input  logic [15:0] audio_l_in,
	input  logic [15:0] audio_r_in,
	input  logic [9:0]  csd_audio,
	input  logic        audio_l,
	input  logic        audio_r,
	output int          errors,
	output logic        audio_done
);

	spyhunt_pkg::mem_write_t q1[$];
	spyhunt_pkg::mem_write_t q2[$];
	spyhunt_pkg::mem_write_t w;
	spyhunt_pkg::rom_region_e reg_m;
	logic        req1_prev;
	logic        req2_prev;
	logic        wr_prev;
	logic        pend_valid;
	logic [24:0] pend_addr;
	logic [7:0]  pend_data;
	logic        err_m;
	logic        dl_prev;
	logic        loaded_m;
	logic        hold_m;
	logic        exp_gr;
	int          since;
	logic        vs_prev;
	logic        sh_prev;
	logic [7:0]  exp_steer;
	logic [7:0]  exp_gas;
	logic [7:0]  nxt_steer;
	logic [7:0]  nxt_gas;
	logic        exp_gear;
	logic        nxt_gear;
	int          cnt_ramp;
	int          cnt_gear;
	int          cyc;
	int          ones_l;
	int          ones_r;

	// main and sound bytes take the same path, so they share one value here
	function automatic spyhunt_pkg::rom_region_e region_of(input logic [24:0] a);
		if (a >= `SPY_IGNORE_BASE)
			return spyhunt_pkg::ignored;
		else if (a >= `SPY_SPRITE_BASE)
			return spyhunt_pkg::sprite;
		else if (a >= `SPY_CSD_BASE)
			return spyhunt_pkg::csd;
		return spyhunt_pkg::main_cpu;
	endfunction

	function automatic spyhunt_pkg::mem_write_t remap(input logic [24:0] a,
		input logic [7:0] d);
		spyhunt_pkg::mem_write_t r;
		logic [24:0] s;
		logic        lane;
		s = a;
		if (region_of(a) == spyhunt_pkg::sprite) begin
			s = a - `SPY_SPRITE_BASE;
			r.addr = {s[23:17], s[14:0], s[16]};
			lane = s[15];
		end else begin
			if (region_of(a) == spyhunt_pkg::csd)
				s = {a[24:15], a[13:0], a[14]};
			r.addr = s[23:1];
			lane = s[0];
		end
		r.ds = lane ? 2'b10 : 2'b01;
		r.data = {d, d};
		return r;
	endfunction

	// one frame step, plus direction first, spring back to center
	function automatic logic [7:0] ramp(input logic [7:0] v, input logic plus,
		input logic minus, input logic spring);
		int n;
		int c;
		n = v;
		c = `SPY_STEER_CENTER;
		if (plus)
			n = n + `SPY_RAMP_STEP;
		else if (minus)
			n = n - `SPY_RAMP_STEP;
		else if (spring && n > c)
			n = (n - `SPY_RAMP_STEP < c) ? c : n - `SPY_RAMP_STEP;
		else if (spring && n < c)
			n = (n + `SPY_RAMP_STEP > c) ? c : n + `SPY_RAMP_STEP;
		if (n > 255)
			n = 255;
		if (n < 0)
			n = 0;
		return n[7:0];
	endfunction

	function automatic int ones_expected(input logic [15:0] main, input logic [9:0] c,
		input int n);
		longint s;
		s = (longint'(main) + longint'(c) * 32) % 65536;
		return int'((longint'(n) * s) / 65536);
	endfunction

	task automatic compare_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic fail(input string what);
		errors++;
		$display("error: %s", what);
	endtask

	task automatic final_report();
		if (q1.size() != 0)
			fail($sformatf("port 1 never wrote %0d routed bytes", q1.size()));
		if (q2.size() != 0)
			fail($sformatf("port 2 never wrote %0d routed bytes", q2.size()));
		if (load_err !== 1'b1)
			fail("overrun did not raise load_err");
	endtask

	initial begin
		errors = 0;
		audio_done = 1'b0;
	end

	always @(posedge clk_sys) begin
		if (!rst_n) begin
			q1.delete();
			q2.delete();
			req1_prev = 1'b0;
			req2_prev = 1'b0;
			wr_prev = 1'b0;
			pend_valid = 1'b0;
			err_m = 1'b0;
			dl_prev = 1'b0;
			loaded_m = 1'b0;
			exp_gr = 1'b1;
			since = 0;
			vs_prev = 1'b0;
			sh_prev = 1'b0;
			exp_steer = `SPY_STEER_CENTER;
			exp_gas = 8'h00;
			exp_gear = 1'b0;
			cnt_ramp = 0;
			cnt_gear = 0;
			cyc = 0;
			ones_l = 0;
			ones_r = 0;
		end else begin
			// ==============================================================
			// download routing
			// ==============================================================
			if (mem1_req !== req1_prev) begin
				if (q1.size() == 0)
					fail("port 1 toggled req with no write expected");
				else
					compare_value("port 1 write", q1.pop_front(),
						{mem1_addr, mem1_ds, mem1_data});
			end
			if (mem2_req !== req2_prev) begin
				if (q2.size() == 0)
					fail("port 2 toggled req with no write expected");
				else
					compare_value("port 2 write", q2.pop_front(),
						{mem2_addr, mem2_ds, mem2_data});
			end
			req1_prev = mem1_req;
			req2_prev = mem2_req;
			compare_value("load_err", err_m, load_err);
			if (pend_valid) begin
				reg_m = region_of(pend_addr);
				w = remap(pend_addr, pend_data);
				// a byte meeting a busy port is lost
				if (reg_m == spyhunt_pkg::sprite) begin
					if (mem2_req !== mem2_ack)
						err_m = 1'b1;
					else
						q2.push_back(w);
				end else if (reg_m != spyhunt_pkg::ignored) begin
					if (mem1_req !== mem1_ack)
						err_m = 1'b1;
					else
						q1.push_back(w);
				end
			end
			pend_valid = dl_wr && !wr_prev && dl_downloading;
			pend_addr = dl_addr;
			pend_data = dl_data;
			wr_prev = dl_wr;

			// ==============================================================
			// reset sequence
			// ==============================================================
			compare_value("game_reset", exp_gr, game_reset);
			compare_value("rom_loaded", loaded_m, rom_loaded);
			hold_m = reset_req || !loaded_m;
			exp_gr = hold_m || (since == `SPY_RESET_HOLD);
			if (hold_m)
				since = 0;
			else if (since < 100000)
				since++;
			if (dl_prev && !dl_downloading)
				loaded_m = 1'b1;
			dl_prev = dl_downloading;

			// ==============================================================
			// driving controls, three cycle latency
			// ==============================================================
			if (cnt_ramp > 0) begin
				cnt_ramp--;
				if (cnt_ramp == 0) begin
					exp_steer = nxt_steer;
					exp_gas = nxt_gas;
				end
			end
			if (cnt_gear > 0) begin
				cnt_gear--;
				if (cnt_gear == 0)
					exp_gear = nxt_gear;
			end
			compare_value("steering", exp_steer, steering);
			compare_value("gas", exp_gas, gas);
			compare_value("gear", exp_gear, gear);
			if (vsync && !vs_prev) begin
				nxt_steer = ramp(exp_steer, steer_right, steer_left, 1'b1);
				nxt_gas = ramp(exp_gas, gas_up, gas_down, 1'b0);
				cnt_ramp = 3;
			end
			if (coin) begin
				nxt_gear = 1'b0;
				cnt_gear = 2;
			end else if (shift && !sh_prev) begin
				nxt_gear = !exp_gear;
				cnt_gear = 3;
			end
			vs_prev = vsync;
			sh_prev = shift;

			// ==============================================================
			// audio pulse density
			// ==============================================================
			cyc++;
			if (cyc >= 2 && cyc <= 4097) begin
				ones_l += (audio_l === 1'b1);
				ones_r += (audio_r === 1'b1);
			end
			if (cyc == 4098) begin
				compare_value("audio_l ones", ones_expected(audio_l_in, csd_audio, 4096),
					ones_l);
				compare_value("audio_r ones", ones_expected(audio_r_in, csd_audio, 4096),
					ones_r);
				audio_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/spyhunt_sva.sv */
// concurrent assertions on the board glue top level
//   memory request handshake, reset hold, control update timing

`default_nettype none

module spyhunt_sva (
	input logic        clk_sys,
	input logic        rst_n,
	input logic        mem1_req,
	input logic [22:0] mem1_addr,
	input logic [1:0]  mem1_ds,
	input logic [15:0] mem1_data,
	input logic        mem2_req,
	input logic [22:0] mem2_addr,
	input logic [1:0]  mem2_ds,
	input logic [15:0] mem2_data,
	input logic        game_reset,
	input logic        rom_loaded,
	input logic        vsync,
	input logic [7:0]  steering,
	input logic [7:0]  gas
);

	int fail_count = 0;

	// every new request carries a new write
	a_req1_new: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mem1_req !== $past(mem1_req)) |-> (mem1_addr !== $past(mem1_addr) ||
		mem1_ds !== $past(mem1_ds) || mem1_data !== $past(mem1_data)))
	else begin
		fail_count++;
		$error("port 1 request toggled without a new write");
	end

	a_req2_new: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mem2_req !== $past(mem2_req)) |-> (mem2_addr !== $past(mem2_addr) ||
		mem2_ds !== $past(mem2_ds) || mem2_data !== $past(mem2_data)))
	else begin
		fail_count++;
		$error("port 2 request toggled without a new write");
	end

	a_reset_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rom_loaded |-> game_reset)
	else begin
		fail_count++;
		$error("game reset low before a ROM was loaded");
	end

	// vsync seen at the port three samples earlier, low the sample before
	a_ramp_time: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(steering !== $past(steering) || gas !== $past(gas)) |->
		($past(vsync, 3) && !$past(vsync, 4)))
	else begin
		fail_count++;
		$error("steering or gas changed outside the frame update slot");
	end

endmodule

bind spyhunt_glue spyhunt_sva u_sva (.*);

`default_nettype wire

/* test/tb_spyhunt.sv */
// testbench of the board glue
//   clock, reset, download and control stimulus,
//   memory acknowledge models, watchdog, final verdict

`default_nettype none

`include "spyhunt_settings.svh"

module tb_spyhunt;

	localparam int clk_period = 4;
	localparam int n_bytes = 14;
	localparam int n_pulses = 80;
	// phase lengths in cycles, audio runs alongside the others
	localparam int dl_cycles = n_bytes * 10 + 20;
	localparam int rst_cycles = 2 * (`SPY_RESET_HOLD + 30);
	localparam int ovr_cycles = 60;
	localparam int ramp_cycles = n_pulses * 9;
	localparam int gear_cycles = 80;
	localparam int audio_cycles = 4100;
	localparam int limit_cycles = dl_cycles + rst_cycles + ovr_cycles + ramp_cycles +
		gear_cycles + audio_cycles + 500;

	logic        clk_sys;
	logic        rst_n;
	logic        dl_downloading;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic        mem1_req;
	logic        mem1_ack;
	logic [22:0] mem1_addr;
	logic [1:0]  mem1_ds;
	logic [15:0] mem1_data;
	logic        mem2_req;
	logic        mem2_ack;
	logic [22:0] mem2_addr;
	logic [1:0]  mem2_ds;
	logic [15:0] mem2_data;
	logic        load_err;
	logic        reset_req;
	logic        game_reset;
	logic        rom_loaded;
	logic        vsync;
	logic        gas_up;
	logic        gas_down;
	logic        steer_right;
	logic        steer_left;
	logic        shift;
	logic        coin;
	logic [7:0]  steering;
	logic [7:0]  gas;
	logic        gear;
	logic [15:0] audio_l_in;
	logic [15:0] audio_r_in;
	logic [9:0]  csd_audio;
	logic        audio_l;
	logic        audio_r;
	int          errors;
	logic        audio_done;
	int          seed = 27;
	logic        hold2;

	spyhunt_glue UUT (.*);

	spyhunt_checker u_checker (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// ======================================================================
	// memory acknowledge models
	// ======================================================================
	initial begin : ack1_model
		int wait_n;
		mem1_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rst_n && mem1_req !== mem1_ack) begin
				wait_n = 1 + ($unsigned($random(seed)) % 4);
				repeat (wait_n - 1) @(negedge clk_sys);
				mem1_ack = mem1_req;
			end
		end
	end

	initial begin : ack2_model
		int wait_n;
		mem2_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rst_n && !hold2 && mem2_req !== mem2_ack) begin
				wait_n = 1 + ($unsigned($random(seed)) % 4);
				repeat (wait_n - 1) @(negedge clk_sys);
				mem2_ack = mem2_req;
			end
		end
	end

	task automatic idle(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// one wr pulse, then quiet until the next byte slot
	task automatic send_byte(input logic [24:0] a, input logic [7:0] d, input int gap);
		@(negedge clk_sys);
		dl_addr = a;
		dl_data = d;
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		idle(gap);
	endtask

	task automatic pulse_vsync();
		idle(2);
		vsync = 1'b1;
		idle(2);
		vsync = 1'b0;
		idle(4);
	endtask

	task automatic press_shift(input int cycles);
		shift = 1'b1;
		idle(cycles);
		shift = 1'b0;
		idle(6);
	endtask

	task automatic insert_coin(input int cycles);
		coin = 1'b1;
		idle(cycles);
		coin = 1'b0;
		idle(6);
	endtask

	initial begin : stimulus
		logic [24:0] byte_addr [0:n_bytes-1];
		int          i;
		int          r;
		byte_addr = '{25'h0000123, 25'h000abcd, 25'h000e001, 25'h000fffe,
			25'h0010000, 25'h0014001, 25'h0017fff, 25'h0018000, 25'h0020001,
			25'h0028000, 25'h0037fff, 25'h0038000, 25'h0040000, 25'h1ffffff};
		rst_n = 1'b0;
		dl_downloading = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		reset_req = 1'b0;
		vsync = 1'b0;
		gas_up = 1'b0;
		gas_down = 1'b0;
		steer_right = 1'b0;
		steer_left = 1'b0;
		shift = 1'b0;
		coin = 1'b0;
		audio_l_in = 16'h1234;
		audio_r_in = 16'hf000;
		csd_audio = 10'h2a5;
		hold2 = 1'b0;
		idle(2);
		rst_n = 1'b1;

		// download into every region
		idle(1);
		dl_downloading = 1'b1;
		idle(4);
		for (i = 0; i < n_bytes; i++) begin
			r = $random(seed);
			send_byte(byte_addr[i], r[7:0], 8);
		end
		idle(4);
		dl_downloading = 1'b0;
		idle(`SPY_RESET_HOLD + 20);

		// reset request repeats the sequence
		reset_req = 1'b1;
		idle(5);
		reset_req = 1'b0;
		idle(`SPY_RESET_HOLD + 20);

		// second download with port 2 stalled
		dl_downloading = 1'b1;
		idle(4);
		hold2 = 1'b1;
		send_byte(25'h0019000, 8'h5a, 0);
		send_byte(25'h001a002, 8'ha5, 10);
		hold2 = 1'b0;
		idle(10);
		dl_downloading = 1'b0;
		idle(10);

		// steering and gas, held first to reach saturation
		for (i = 0; i < n_pulses; i++) begin
			r = $random(seed);
			steer_right = (i < 36) ? 1'b1 : r[0];
			steer_left = r[1];
			gas_up = (i < 68) ? 1'b1 : r[2];
			gas_down = r[3];
			pulse_vsync();
		end
		steer_right = 1'b0;
		steer_left = 1'b0;
		gas_up = 1'b0;
		gas_down = 1'b0;

		// gear lever
		for (i = 0; i < 3; i++)
			press_shift(2);
		insert_coin(1);
		press_shift(2);
		insert_coin(1);

		wait (audio_done === 1'b1);
		idle(2);
		u_checker.final_report();
		$display("errors: checks %0d, assertions %0d", errors, UUT.u_sva.fail_count);
		if (errors == 0 && UUT.u_sva.fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		#(limit_cycles * clk_period);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
